//--- vlog.f
rtl/cache_pkg.sv
rtl/set_ram.sv
rtl/way_select.sv
rtl/line_walker.sv
rtl/cache_ctrl.sv
rtl/l1_cache.sv
sim/mem_model.sv
sim/tb_l1_cache.sv

//--- Makefile
TOP = tb_l1_cache

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f rtl/*.sv sim/*.sv
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "TEST OK" sim.log

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_l1_cache.sv
/*
 * testbench for the L1 data cache
 * clock, reset, request tasks, shadow memory with byte merge,
 * concurrent checks on processor and memory traffic
 */
module tb_l1_cache;
    import cache_pkg::*;

    localparam int N_SETS     = 16;
    localparam int BLOCK_SIZE = 4;
    localparam int WORDS      = 1024;  // 4 KB test window
    localparam int LINE_LSB   = $clog2(BLOCK_SIZE) + 2;
    localparam int TAG_LSB    = LINE_LSB + $clog2(N_SETS);
    localparam int TIMEOUT    = 200;

    logic     CLK, nRST;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    word_t shadow [WORDS];
    word_t exp_rdata, exp_wdata;
    logic  expect_hit, started, req_on, in_miss;
    int    rd_cnt, wr_cnt, errors, timeouts;

    l1_cache #(.N_SETS(N_SETS), .BLOCK_SIZE(BLOCK_SIZE)) u_l1_cache (
        .CLK, .nRST, .cpu_req, .cpu_rsp, .mem_req, .mem_rsp
    );

    mem_model #(.WORDS(WORDS), .SEED(32'ha5cf_183c)) u_mem (
        .CLK, .nRST, .req(mem_req), .rsp(mem_rsp)
    );

    always #4 CLK = ~CLK;

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input be_t be);
        word_t r;
        r = old_w;
        for (int k = 0; k < 4; k++) begin
            if (be[k]) begin
                r[8*k +: 8] = new_w[8*k +: 8];
            end
        end
        return r;
    endfunction

    assign req_on    = cpu_req.ren | cpu_req.wen;
    assign exp_rdata = shadow[cpu_req.addr[$clog2(WORDS)+1:2]];
    assign exp_wdata = shadow[mem_req.addr[$clog2(WORDS)+1:2]];

    // shadow memory and per-miss word counters
    always @(posedge CLK) begin
        if (!nRST) begin
            for (int i = 0; i < WORDS; i++) begin
                shadow[i] <= 32'(i) ^ 32'h5a5a_0000;
            end
            in_miss <= 1'b0;
            rd_cnt  <= 0;
            wr_cnt  <= 0;
        end else if (req_on && !cpu_rsp.busy) begin
            if (cpu_req.wen) begin
                shadow[cpu_req.addr[$clog2(WORDS)+1:2]] <=
                    merge_bytes(exp_rdata, cpu_req.wdata, cpu_req.byte_en);
            end
            in_miss <= 1'b0;
            rd_cnt  <= 0;
            wr_cnt  <= 0;
        end else begin
            if (req_on) in_miss <= 1'b1;
            if (mem_req.ren && !mem_rsp.busy) rd_cnt <= rd_cnt + 1;
            if (mem_req.wen && !mem_rsp.busy) wr_cnt <= wr_cnt + 1;
        end
    end

    a_quiet_after_reset: assert property (@(posedge CLK)
        !started |-> !(mem_req.ren || mem_req.wen))
        else begin
            errors++;
            $display("memory request issued before any processor request");
        end

    a_read_data: assert property (@(posedge CLK) disable iff (!nRST)
        cpu_req.ren && !cpu_rsp.busy |-> cpu_rsp.rdata == exp_rdata)
        else begin
            errors++;
            $display("FAILED %0t: read of %h returned %h, expected %h",
                     $time, cpu_req.addr, cpu_rsp.rdata, exp_rdata);
        end

    a_hit_no_wait: assert property (@(posedge CLK) disable iff (!nRST)
        expect_hit && req_on |-> !cpu_rsp.busy)
        else begin
            errors++;
            $display("request to a resident line was not accepted at once");
        end

    a_mem_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else begin
            errors++;
            $display("memory read and write overlap");
        end

    a_mem_window: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.ren || mem_req.wen) |-> mem_req.addr < 32'(WORDS * 4))
        else begin
            errors++;
            $display("FAILED %0t: memory address %h outside the test window",
                     $time, mem_req.addr);
        end

    // a writeback stays in the requested set but never hits the requested line
    a_wb_line: assert property (@(posedge CLK) disable iff (!nRST)
        mem_req.wen |-> mem_req.addr[1:0] == 2'b00
            && mem_req.addr[TAG_LSB-1:LINE_LSB] == cpu_req.addr[TAG_LSB-1:LINE_LSB]
            && mem_req.addr[31:TAG_LSB] != cpu_req.addr[31:TAG_LSB])
        else begin
            errors++;
            $display("FAILED %0t: writeback address %h not in the evicted line",
                     $time, mem_req.addr);
        end

    a_wb_data: assert property (@(posedge CLK) disable iff (!nRST)
        mem_req.wen && !mem_rsp.busy |-> mem_req.wdata == exp_wdata)
        else begin
            errors++;
            $display("FAILED %0t: writeback to %h carries %h, expected %h",
                     $time, mem_req.addr, mem_req.wdata, exp_wdata);
        end

    a_line_reads: assert property (@(posedge CLK) disable iff (!nRST)
        req_on && !cpu_rsp.busy && in_miss |-> rd_cnt == BLOCK_SIZE)
        else begin
            errors++;
            $display("FAILED %0t: refill moved %0d words, expected %0d",
                     $time, rd_cnt, BLOCK_SIZE);
        end

    a_line_writes: assert property (@(posedge CLK) disable iff (!nRST)
        req_on && !cpu_rsp.busy && in_miss |-> (wr_cnt == 0 || wr_cnt == BLOCK_SIZE))
        else begin
            errors++;
            $display("FAILED %0t: writeback moved %0d words, expected 0 or %0d",
                     $time, wr_cnt, BLOCK_SIZE);
        end

    // drive one request and hold it until accepted
    task automatic access(input logic write, input addr_t addr, input word_t data,
                          input be_t be, input logic hit_known);
        int n;
        cpu_req.ren     = !write;
        cpu_req.wen     = write;
        cpu_req.addr    = addr;
        cpu_req.wdata   = data;
        cpu_req.byte_en = be;
        expect_hit      = hit_known;
        started         = 1'b1;
        n = 0;
        @(negedge CLK);
        while (cpu_rsp.busy && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (cpu_rsp.busy) begin
            timeouts++;
            $display("timeout: request to %h was never accepted", addr);
        end
        @(posedge CLK);
        #1;
        cpu_req    = '0;
        expect_hit = 1'b0;
    endtask

    task automatic read_word(input addr_t addr, input logic hit_known);
        access(1'b0, addr, '0, 4'b0000, hit_known);
    endtask

    task automatic write_word(input addr_t addr, input word_t data, input be_t be,
                              input logic hit_known);
        access(1'b1, addr, data, be, hit_known);
    endtask

    initial begin
        CLK        = 1'b0;
        nRST       = 1'b0;
        cpu_req    = '0;
        expect_hit = 1'b0;
        started    = 1'b0;
        errors     = 0;
        timeouts   = 0;
        repeat (5) @(posedge CLK);
        #1 nRST = 1'b1;
        repeat (3) @(posedge CLK);   // idle cycles with a quiet memory
        #1;

        read_word(32'h014, 1'b0);    // clean miss in set 1
        read_word(32'h014, 1'b1);
        read_word(32'h018, 1'b1);
        write_word(32'h018, 32'hdead_beef, 4'b0101, 1'b1);
        read_word(32'h018, 1'b1);
        write_word(32'h11c, 32'h0bad_cafe, 4'b1110, 1'b0);  // allocating miss into the other way
        read_word(32'h11c, 1'b1);

        // third tag in set 1 evicts both dirty lines in turn
        read_word(32'h210, 1'b0);
        read_word(32'h018, 1'b0);
        read_word(32'h11c, 1'b0);
        write_word(32'h21c, 32'h1234_5678, 4'b0011, 1'b0);
        read_word(32'h21c, 1'b1);

        // many tags in sets 0, 4, 8 and 12 with every byte_en pattern
        for (int i = 0; i < 16; i++) begin
            write_word(32'(i * 64 + 4), 32'h1357_9bdf ^ (32'(i) * 32'h0101_0101), 4'(i), 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            read_word(32'(i * 64 + 4), 1'b0);
            read_word(32'(i * 64 + 8), 1'b1);
        end

        repeat (2) @(posedge CLK);
        assert (u_mem.wr_log.size() > 0 && u_mem.wr_log.size() % BLOCK_SIZE == 0)
        else begin
            errors++;
            $display("FAILED %0t: memory received %0d written words, not whole lines",
                     $time, u_mem.wr_log.size());
        end

        $display("closing: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sim/mem_model.sv
/*
 * word-addressed memory behind the cache
 * each word starts as its word address xor 32'h5a5a_0000,
 * random 0..3 cycle stall per word from an xorshift generator,
 * log of the byte address of every word written
 */
module mem_model #(
    parameter int          WORDS = 1024,
    parameter logic [31:0] SEED  = 32'ha5cf_183c
) (
    input  logic                CLK,
    input  logic                nRST,
    input  cache_pkg::mem_req_t req,
    output cache_pkg::mem_rsp_t rsp
);
    import cache_pkg::*;

    localparam int AW = $clog2(WORDS);

    word_t       mem [WORDS];
    addr_t       wr_log [$];    // in arrival order
    logic [31:0] rng, rng_n;
    logic [1:0]  stall;         // wait cycles left for the current word
    logic        active;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign active    = req.ren | req.wen;
    assign rng_n     = xorshift32(rng);
    assign rsp.busy  = active && (stall != 2'd0);
    assign rsp.rdata = req.ren ? mem[req.addr[AW+1:2]] : '0;

    // the stall of the next word is drawn when the current one completes
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rng   <= SEED;
            stall <= 2'd0;
        end else if (active) begin
            if (stall != 2'd0) begin
                stall <= stall - 2'd1;
            end else begin
                rng   <= rng_n;
                stall <= rng_n[1:0];
            end
        end
    end

    always @(posedge CLK) begin
        if (!nRST) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= 32'(i) ^ 32'h5a5a_0000;   // fill while in reset
            end
        end else if (req.wen && !rsp.busy) begin
            mem[req.addr[AW+1:2]] <= req.wdata;
            wr_log.push_back(req.addr);
        end
    end

endmodule

//--- rtl/l1_cache.sv
/*
 * L1 data cache top level, 2-way, write-back, write-allocate
 * builds the tag and data line types from the geometry
 * and connects the FSM to tag compare, line walker and storage
 */
module l1_cache #(
    parameter int N_SETS     = 16,  // power of two
    parameter int BLOCK_SIZE = 4    // power-of-two words per line
) (
    input  logic                CLK,
    input  logic                nRST,
    input  cache_pkg::cpu_req_t cpu_req,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);
    import cache_pkg::*;

    localparam int IDX_W = $clog2(N_SETS);
    localparam int OFF_W = $clog2(BLOCK_SIZE);
    localparam int TAG_W = 32 - IDX_W - OFF_W - 2;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_way_t;

    typedef tag_way_t [N_WAYS-1:0]   tag_entry_t;
    typedef word_t [BLOCK_SIZE-1:0]  line_t;
    typedef line_t [N_WAYS-1:0]      data_entry_t;

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] req_tag, victim_tag;
    addr_t            line_addr, victim_base, mem_addr;
    logic             hit, victim_dirty, touch, last;
    way_t             hit_way, victim_way, touch_way;
    logic [OFF_W-1:0] offset;
    logic             start_fetch, start_writeback, advance;
    logic             tag_wen, data_wen;
    tag_entry_t       tag_rd, tag_wmask, tag_wdata;
    data_entry_t      data_rd, data_wmask, data_wdata;

    // address split  tag | index | word offset | byte
    assign idx         = cpu_req.addr[OFF_W+2 +: IDX_W];
    assign req_tag     = cpu_req.addr[31 -: TAG_W];
    assign line_addr   = {cpu_req.addr[31:OFF_W+2], {(OFF_W+2){1'b0}}};
    assign victim_base = {victim_tag, idx, {(OFF_W+2){1'b0}}};

    cache_ctrl #(.N_SETS(N_SETS), .BLOCK_SIZE(BLOCK_SIZE),
                 .tag_entry_t(tag_entry_t), .data_entry_t(data_entry_t)) u_cache_ctrl (
        .CLK, .nRST, .cpu_req, .cpu_rsp, .mem_req, .mem_rsp,
        .hit, .hit_way, .victim_way, .victim_dirty, .touch, .touch_way,
        .offset, .mem_addr, .last, .start_fetch, .start_writeback, .advance,
        .tag_rd, .data_rd, .tag_wen, .tag_wmask, .tag_wdata,
        .data_wen, .data_wmask, .data_wdata
    );

    way_select #(.N_SETS(N_SETS), .TAG_W(TAG_W), .tag_entry_t(tag_entry_t)) u_way_select (
        .CLK, .nRST, .idx, .req_tag, .tags(tag_rd), .touch, .touch_way,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    line_walker #(.BLOCK_SIZE(BLOCK_SIZE)) u_line_walker (
        .CLK, .nRST, .start_fetch, .start_writeback, .line_addr, .victim_base,
        .advance, .offset, .mem_addr, .last
    );

    set_ram #(.N_SETS(N_SETS), .entry_t(tag_entry_t)) u_tag_ram (
        .CLK, .nRST, .sel(idx), .wen(tag_wen), .wmask(tag_wmask),
        .wdata(tag_wdata), .rdata(tag_rd)
    );

    set_ram #(.N_SETS(N_SETS), .entry_t(data_entry_t)) u_data_ram (
        .CLK, .nRST, .sel(idx), .wen(data_wen), .wmask(data_wmask),
        .wdata(data_wdata), .rdata(data_rd)
    );

endmodule

//--- rtl/cache_ctrl.sv
/*
 * miss FSM for the L1 data cache (IDLE, WRITEBACK, REFILL)
 * processor busy and read data, memory request,
 * byte-merge and write controls for tag and data storage
 */
module cache_ctrl #(
    parameter int  N_SETS       = 16,
    parameter int  BLOCK_SIZE   = 4,
    parameter type tag_entry_t  = logic,
    parameter type data_entry_t = logic
) (
    input  logic                          CLK,
    input  logic                          nRST,
    input  cache_pkg::cpu_req_t           cpu_req,
    output cache_pkg::cpu_rsp_t           cpu_rsp,
    output cache_pkg::mem_req_t           mem_req,
    input  cache_pkg::mem_rsp_t           mem_rsp,
    input  logic                          hit,
    input  cache_pkg::way_t               hit_way,
    input  cache_pkg::way_t               victim_way,
    input  logic                          victim_dirty,
    output logic                          touch,
    output cache_pkg::way_t               touch_way,
    input  logic [$clog2(BLOCK_SIZE)-1:0] offset,
    input  cache_pkg::addr_t              mem_addr,
    input  logic                          last,
    output logic                          start_fetch,
    output logic                          start_writeback,
    output logic                          advance,
    input  tag_entry_t                    tag_rd,
    input  data_entry_t                   data_rd,
    output logic                          tag_wen,
    output tag_entry_t                    tag_wmask,
    output tag_entry_t                    tag_wdata,
    output logic                          data_wen,
    output data_entry_t                   data_wmask,
    output data_entry_t                   data_wdata
);
    import cache_pkg::*;

    localparam int OFF_W = $clog2(BLOCK_SIZE);
    localparam int IDX_W = $clog2(N_SETS);
    localparam int TAG_W = 32 - IDX_W - OFF_W - 2;

    typedef enum logic [1:0] {IDLE, WRITEBACK, REFILL} state_t;

    state_t           state, state_n;
    logic             fill_done, fill_done_n;  // all words in and the tag write pending
    logic             req;
    logic [OFF_W-1:0] word_off;
    logic [TAG_W-1:0] req_tag;
    word_t            byte_mask;

    assign req      = cpu_req.ren | cpu_req.wen;
    assign word_off = cpu_req.addr[OFF_W+1:2];
    assign req_tag  = cpu_req.addr[31 -: TAG_W];

    // byte lane k is written when byte_en[k] is set
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            byte_mask[8*k +: 8] = {8{cpu_req.byte_en[k]}};
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            fill_done <= 1'b0;
        end else begin
            state     <= state_n;
            fill_done <= fill_done_n;
        end
    end

    always_comb begin
        state_n         = state;
        fill_done_n     = fill_done;
        cpu_rsp.busy    = req;     // released only on a hit in IDLE
        cpu_rsp.rdata   = data_rd[hit_way][word_off];
        mem_req         = '0;
        touch           = 1'b0;
        touch_way       = hit_way;
        start_fetch     = 1'b0;
        start_writeback = 1'b0;
        advance         = 1'b0;
        tag_wen         = 1'b0;
        tag_wmask       = '0;
        tag_wdata       = tag_rd;
        data_wen        = 1'b0;
        data_wmask      = '0;
        data_wdata      = data_rd;

        case (state)
            IDLE: begin
                if (req && hit) begin
                    cpu_rsp.busy = 1'b0;
                    touch        = 1'b1;
                    if (cpu_req.wen) begin
                        data_wen                          = 1'b1;
                        data_wmask[hit_way][word_off]     = byte_mask;
                        data_wdata[hit_way][word_off]     = cpu_req.wdata;
                        tag_wen                           = 1'b1;
                        tag_wmask[hit_way].dirty          = 1'b1;
                        tag_wdata[hit_way].dirty          = 1'b1;
                    end
                end else if (req) begin
                    if (victim_dirty) begin
                        start_writeback = 1'b1;
                        state_n         = WRITEBACK;
                    end else begin
                        start_fetch = 1'b1;
                        state_n     = REFILL;
                    end
                end
            end

            WRITEBACK: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = mem_addr;
                mem_req.wdata = data_rd[victim_way][offset];
                if (!mem_rsp.busy) begin
                    advance = 1'b1;
                    if (last) begin
                        // victim is clean now and the walker reloads with the request line
                        tag_wen                     = 1'b1;
                        tag_wmask[victim_way].dirty = 1'b1;
                        tag_wdata[victim_way].dirty = 1'b0;
                        start_fetch                 = 1'b1;
                        state_n                     = REFILL;
                    end
                end
            end

            REFILL: begin
                if (fill_done) begin
                    tag_wen                     = 1'b1;
                    tag_wmask[victim_way]       = '1;
                    tag_wdata[victim_way].valid = 1'b1;
                    tag_wdata[victim_way].dirty = 1'b0;
                    tag_wdata[victim_way].tag   = req_tag;
                    fill_done_n                 = 1'b0;
                    state_n                     = IDLE;
                end else begin
                    mem_req.ren  = 1'b1;
                    mem_req.addr = mem_addr;
                    if (!mem_rsp.busy) begin
                        data_wen                       = 1'b1;
                        data_wmask[victim_way][offset] = '1;
                        data_wdata[victim_way][offset] = mem_rsp.rdata;
                        advance                        = 1'b1;
                        fill_done_n                    = last;
                    end
                end
            end

            default: state_n = IDLE;
        endcase
    end

    a_mem_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else $error("memory read and write requested together");

    // a stalled memory transfer must see the same address and data next cycle
    a_mem_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.ren || mem_req.wen) && mem_rsp.busy |=> $stable(mem_req))
        else $error("memory request changed while stalled");

    // the miss path indexes storage straight from the processor address
    a_cpu_hold: assert property (@(posedge CLK) disable iff (!nRST)
        cpu_rsp.busy |=> $stable(cpu_req))
        else $error("processor request changed while busy");

endmodule

//--- rtl/line_walker.sv
/*
 * word counter and memory address register
 * steps through one line during a writeback or a refill
 */
module line_walker #(
    parameter int BLOCK_SIZE = 4
) (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          start_fetch,
    input  logic                          start_writeback,
    input  cache_pkg::addr_t              line_addr,
    input  cache_pkg::addr_t              victim_base,
    input  logic                          advance,
    output logic [$clog2(BLOCK_SIZE)-1:0] offset,
    output cache_pkg::addr_t              mem_addr,
    output logic                          last
);

    localparam int OFF_W = $clog2(BLOCK_SIZE);

    // a start wins over an advance in the same cycle
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            offset   <= '0;
            mem_addr <= '0;
        end else if (start_fetch) begin
            offset   <= '0;
            mem_addr <= line_addr;       // line base of the request
        end else if (start_writeback) begin
            offset   <= '0;
            mem_addr <= victim_base;     // line base of the victim
        end else if (advance) begin
            offset   <= offset + 1'b1;
            mem_addr <= mem_addr + 32'd4;
        end
    end

    assign last = (offset == OFF_W'(BLOCK_SIZE - 1));

endmodule

//--- rtl/way_select.sv
/*
 * tag compare across both ways of a set
 * hit and hit way, per-set LRU bit,
 * victim way with its dirty flag and tag
 */
module way_select #(
    parameter int  N_SETS      = 16,
    parameter int  TAG_W       = 24,
    parameter type tag_entry_t = logic
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic [$clog2(N_SETS)-1:0] idx,
    input  logic [TAG_W-1:0]          req_tag,
    input  tag_entry_t                tags,
    input  logic                      touch,
    input  cache_pkg::way_t           touch_way,
    output logic                      hit,
    output cache_pkg::way_t           hit_way,
    output cache_pkg::way_t           victim_way,
    output logic                      victim_dirty,
    output logic [TAG_W-1:0]          victim_tag
);
    import cache_pkg::*;

    way_t [N_SETS-1:0]  lru;   // way last used in each set
    logic [N_WAYS-1:0]  match;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            match[w] = tags[w].valid && (tags[w].tag == req_tag);
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |match;

    // with two ways the victim is simply the other one
    assign victim_way   = ~lru[idx];
    assign victim_dirty = tags[victim_way].valid && tags[victim_way].dirty;
    assign victim_tag   = tags[victim_way].tag;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lru <= '0;
        end else if (touch) begin
            lru[idx] <= touch_way;
        end
    end

    // a refill must never install a tag that is already present in the set
    a_single_hit: assert property (@(posedge CLK) disable iff (!nRST) !(&match))
        else $error("tag matches in both ways of set %0d", idx);

endmodule

//--- rtl/set_ram.sv
/*
 * set-indexed storage array
 * asynchronous read of the selected entry,
 * synchronous write of the bits picked by the mask
 */
module set_ram #(
    parameter int  N_SETS  = 16,
    parameter type entry_t = logic
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic [$clog2(N_SETS)-1:0] sel,
    input  logic                      wen,
    input  entry_t                    wmask,
    input  entry_t                    wdata,
    output entry_t                    rdata
);

    entry_t mem [N_SETS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < N_SETS; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            // keep unmasked bits, take masked bits from wdata
            mem[sel] <= entry_t'((mem[sel] & ~wmask) | (wdata & wmask));
        end
    end

    assign rdata = mem[sel];  // same-cycle read

endmodule

//--- rtl/cache_pkg.sv
/*
 * shared types for the L1 data cache
 * word, address and byte-enable types, way count and way index,
 * processor and memory bus request/response structs
 */
package cache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  be_t;     // one bit per byte lane

    localparam int N_WAYS = 2;
    typedef logic [$clog2(N_WAYS)-1:0] way_t;

    // processor request is held steady while busy
    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t wdata;
        be_t   byte_en;
    } cpu_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } cpu_rsp_t;

    // memory side always moves whole words
    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } mem_rsp_t;

endpackage
